/* list.f */
+incdir+rtl
rtl/mcu_pkg.sv
rtl/bus_decoder.sv
rtl/main_ram.sv
rtl/video_ram.sv
rtl/io_regs.sv
rtl/clock_timer.sv
rtl/buzzer.sv
rtl/mcu_peripherals.sv
test/tb_mcu_peripherals.sv

/* rtl/bus_decoder.sv */
`timescale 1ns/1ps
`include "mcu_defs.svh"

module bus_decoder import mcu_pkg::*; (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        clk_en,
  input  cpu_addr_t   mem_addr,
  input  nibble_t     mem_write_data,
  input  logic        mem_write_en,
  input  logic        mem_read_en,
  output nibble_t     mem_read_data,
  output logic        ram_wren,
  output ram_addr_t   ram_addr,
  output logic        video_wren,
  output video_addr_t video_cpu_addr,
  output logic        io_write,
  output logic        io_read,
  output io_offset_t  io_offset,
  output nibble_t     wdata,
  input  nibble_t     ram_q,
  input  nibble_t     video_q,
  input  nibble_t     io_rdata
);

  logic in_ram;
  logic in_seg_lo;
  logic in_seg_hi;
  logic in_io;
  logic access;

  // Region decode
  assign in_ram    = mem_addr < `RAM_END;
  assign in_seg_lo = (mem_addr >= `SEG_LO_START) && (mem_addr < `SEG_LO_END);
  assign in_seg_hi = (mem_addr >= `SEG_HI_START) && (mem_addr < `SEG_HI_END);
  assign in_io     = mem_addr[11:8] == `IO_PAGE;

  assign access = clk_en && (mem_write_en || mem_read_en);

  // Addresses run ahead of the tick so the synchronous RAMs can read
  assign ram_addr       = mem_addr[9:0];
  assign video_cpu_addr = {1'b0, mem_addr[6:0]} + (in_seg_hi ? `SEG_HI_BASE : 8'h00);
  assign io_offset      = mem_addr[7:0];
  assign wdata          = mem_write_data;

  assign ram_wren   = clk_en && mem_write_en && in_ram;
  assign video_wren = clk_en && mem_write_en && (in_seg_lo || in_seg_hi);
  assign io_write   = clk_en && mem_write_en && in_io;
  assign io_read    = clk_en && mem_read_en && in_io;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      mem_read_data <= '0;
    end else if (access) begin
      if (in_ram) begin
        mem_read_data <= ram_q;
      end else if (in_seg_lo || in_seg_hi) begin
        mem_read_data <= video_q;
      end else if (in_io) begin
        mem_read_data <= io_rdata;
      end else begin
        // Unmapped
        mem_read_data <= '0;
      end
    end
  end

  // One region per access, the CPU never drives both strobes
  a_one_region: assert property (@(posedge clk) disable iff (!reset_n)
    $onehot0({ram_wren, video_wren, io_write, io_read}));

endmodule

/* rtl/buzzer.sv */
`timescale 1ns/1ps
`include "mcu_defs.svh"

module buzzer (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       clk_en,
  input  logic       buzzer_enabled,
  input  logic [2:0] buzzer_freq,
  output logic       tone
);

  // Shortest half-period in ticks
  localparam logic [3:0] HALF_BASE = 4'd2;

  logic [3:0] count;
  logic [3:0] half_period;

  assign half_period = HALF_BASE + {1'b0, buzzer_freq};

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      count <= '0;
      tone  <= 1'b0;
    end else if (!buzzer_enabled) begin
      // Silent, and the next tone starts from a full half-period
      count <= '0;
      tone  <= 1'b0;
    end else if (clk_en) begin
      if (count >= half_period - 4'd1) begin
        count <= '0;
        tone  <= ~tone;
      end else begin
        count <= count + 4'd1;
      end
    end
  end

endmodule

/* rtl/clock_timer.sv */
`timescale 1ns/1ps
`include "mcu_defs.svh"

module clock_timer import mcu_pkg::*; (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       clk_en,
  input  logic       timer_reset,
  input  logic       factor_clear,
  output logic [7:0] timer_value,
  output nibble_t    clock_factor
);

  localparam int PRESCALE_W = $clog2(`TIMER_PRESCALE);

  logic [PRESCALE_W-1:0] prescale;
  logic                  step;
  logic [7:0]            timer_next;
  logic [7:0]            falling;
  nibble_t               factor_set;

  assign step       = clk_en && (prescale == PRESCALE_W'(`TIMER_PRESCALE - 1));
  assign timer_next = timer_value + 8'd1;

  // Bits that drop from 1 to 0 on this step
  assign falling = step ? (timer_value & ~timer_next) : '0;

  // 32 Hz, 8 Hz, 2 Hz and 1 Hz taps
  assign factor_set = timer_reset ? '0 : {falling[7], falling[6], falling[4], falling[2]};

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      prescale     <= '0;
      timer_value  <= '0;
      clock_factor <= '0;
    end else begin
      if (timer_reset) begin
        prescale    <= '0;
        timer_value <= '0;
      end else if (clk_en) begin
        prescale <= step ? '0 : prescale + 1'b1;
        if (step) begin
          timer_value <= timer_next;
        end
      end
      // A new set beats a clear in the same cycle
      clock_factor <= (factor_clear ? '0 : clock_factor) | factor_set;
    end
  end

endmodule

/* rtl/io_regs.sv */
`timescale 1ns/1ps
`include "mcu_defs.svh"

module io_regs import mcu_pkg::*; (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       io_write,
  input  logic       io_read,
  input  io_offset_t io_offset,
  input  nibble_t    wdata,
  output nibble_t    io_rdata,
  input  nibble_t    k0,
  input  nibble_t    k1,
  input  logic [7:0] timer_value,
  input  nibble_t    clock_factor,
  output logic       timer_reset,
  output logic       factor_clear,
  output logic       buzzer_enabled,
  output logic [2:0] buzzer_freq,
  output logic       lcd_all_off,
  output logic       lcd_all_on,
  output logic       irq
);

  nibble_t    clock_mask;
  nibble_t    k0_mask;
  nibble_t    k1_mask;
  nibble_t    relation;
  nibble_t    buzz_ctrl;
  nibble_t    buzz_freq;
  logic [2:0] lcd_control;
  logic       heavy_load;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      clock_mask                <= '0;
      k0_mask                   <= '0;
      k1_mask                   <= '0;
      relation                  <= `RELATION;
      buzz_ctrl                 <= `BUZZ_CTRL;
      buzz_freq                 <= `BUZZ_FREQ;
      {lcd_control, heavy_load} <= `LCD_CTRL;
      timer_reset               <= 1'b0;
      factor_clear              <= 1'b0;
    end else begin
      // Pulses last one cycle
      timer_reset  <= io_write && (io_offset == `IO_TIMER_RESET) && wdata[1];
      factor_clear <= io_read && (io_offset == `IO_CLOCK_FACTOR);

      if (io_write) begin
        case (io_offset)
          `IO_CLOCK_MASK: clock_mask <= wdata;
          `IO_K0_MASK:    k0_mask    <= wdata;
          `IO_K1_MASK:    k1_mask    <= wdata;
          `IO_RELATION:   relation   <= wdata;
          `IO_BUZZ_CTRL:  buzz_ctrl  <= wdata;
          `IO_LCD_CTRL:   {lcd_control, heavy_load} <= wdata;
          `IO_BUZZ_FREQ:  buzz_freq  <= wdata;
          default: ;
        endcase
      end
    end
  end

  // Read mux, unhandled offsets read as 0
  always_comb begin
    case (io_offset)
      `IO_CLOCK_FACTOR: io_rdata = clock_factor;
      `IO_CLOCK_MASK:   io_rdata = clock_mask;
      `IO_K0_MASK:      io_rdata = k0_mask;
      `IO_K1_MASK:      io_rdata = k1_mask;
      `IO_TIMER_LO:     io_rdata = timer_value[3:0];
      `IO_TIMER_HI:     io_rdata = timer_value[7:4];
      `IO_K0:           io_rdata = k0;
      `IO_RELATION:     io_rdata = relation;
      `IO_K1:           io_rdata = k1;
      `IO_BUZZ_CTRL:    io_rdata = buzz_ctrl;
      `IO_LCD_CTRL:     io_rdata = {lcd_control, heavy_load};
      `IO_BUZZ_FREQ:    io_rdata = buzz_freq;
      default:          io_rdata = '0;
    endcase
  end

  // R43 low enables the tone
  assign buzzer_enabled = ~buzz_ctrl[3];
  assign buzzer_freq    = buzz_freq[2:0];

  assign lcd_all_off = lcd_control[2];
  assign lcd_all_on  = lcd_control[1];

  assign irq = |(clock_factor & clock_mask);

endmodule

/* rtl/main_ram.sv */
`timescale 1ns/1ps
`include "mcu_defs.svh"

module main_ram import mcu_pkg::*; (
  input  logic      clk,
  input  ram_addr_t cpu_addr,
  input  nibble_t   cpu_data,
  input  logic      cpu_wren,
  input  logic      ss_active,
  input  ram_addr_t ss_addr,
  input  nibble_t   ss_data,
  input  logic      ss_wren,
  output nibble_t   q
);

  nibble_t   mem [0:`RAM_END-1];

  ram_addr_t addr;
  nibble_t   data;
  logic      wren;

  // State port takes the whole RAM, CPU writes are dropped meanwhile
  assign addr = ss_active ? ss_addr : cpu_addr;
  assign data = ss_active ? ss_data : cpu_data;
  assign wren = ss_active ? ss_wren : cpu_wren;

  always_ff @(posedge clk) begin
    if (wren) begin
      mem[addr] <= data;
    end
    q <= mem[addr];
  end

  // Neither the decoder nor the state port may write past the array
  a_write_in_range: assert property (@(posedge clk) wren |-> ({2'b00, addr} < `RAM_END));

endmodule

/* rtl/mcu_defs.svh */
`ifndef MCU_DEFS_SVH
`define MCU_DEFS_SVH

// Memory map
`define RAM_END         12'h280
`define SEG_LO_START    12'hE00
`define SEG_LO_END      12'hE50
`define SEG_HI_START    12'hE80
`define SEG_HI_END      12'hED0
`define SEG_HI_BASE     8'h50
`define VIDEO_SIZE      8'hA0
`define IO_PAGE         4'hF

// Offsets inside the I/O page
`define IO_CLOCK_FACTOR 8'h00
`define IO_CLOCK_MASK   8'h10
`define IO_K0_MASK      8'h14
`define IO_K1_MASK      8'h15
`define IO_TIMER_LO     8'h20
`define IO_TIMER_HI     8'h21
`define IO_K0           8'h40
`define IO_RELATION     8'h41
`define IO_K1           8'h42
`define IO_BUZZ_CTRL    8'h54
`define IO_LCD_CTRL     8'h71
`define IO_BUZZ_FREQ    8'h74
`define IO_TIMER_RESET  8'h76

// clk_en ticks per clock timer step
`define TIMER_PRESCALE  4

// Reset defaults
`define BUZZ_CTRL       4'hF
`define BUZZ_FREQ       4'hF
`define RELATION        4'hF
// lcd_control = 100, heavy load = 0
`define LCD_CTRL        4'h8

`endif

/* rtl/mcu_peripherals.sv */
`timescale 1ns/1ps

module mcu_peripherals import mcu_pkg::*; (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        clk_en,

  // CPU data bus
  input  cpu_addr_t   mem_addr,
  input  nibble_t     mem_write_data,
  input  logic        mem_write_en,
  input  logic        mem_read_en,
  output nibble_t     mem_read_data,

  // Display read port
  input  video_addr_t video_addr,
  output nibble_t     video_data,

  input  nibble_t     k0,
  input  nibble_t     k1,

  output logic        buzzer,
  output logic        irq,
  output logic        lcd_all_off,
  output logic        lcd_all_on,

  // State access to main RAM
  input  logic        ss_active,
  input  logic        ss_wren,
  input  ram_addr_t   ss_addr,
  input  nibble_t     ss_data,
  output nibble_t     ss_q
);

  logic        ram_wren;
  ram_addr_t   ram_addr;
  logic        video_wren;
  video_addr_t video_cpu_addr;
  logic        io_write;
  logic        io_read;
  io_offset_t  io_offset;
  nibble_t     wdata;

  nibble_t     ram_q;
  nibble_t     video_q;
  nibble_t     io_rdata;

  logic [7:0]  timer_value;
  nibble_t     clock_factor;
  logic        timer_reset;
  logic        factor_clear;

  logic        buzzer_enabled;
  logic [2:0]  buzzer_freq;

  bus_decoder decoder0 (
    .clk            (clk),
    .reset_n        (reset_n),
    .clk_en         (clk_en),
    .mem_addr       (mem_addr),
    .mem_write_data (mem_write_data),
    .mem_write_en   (mem_write_en),
    .mem_read_en    (mem_read_en),
    .mem_read_data  (mem_read_data),
    .ram_wren       (ram_wren),
    .ram_addr       (ram_addr),
    .video_wren     (video_wren),
    .video_cpu_addr (video_cpu_addr),
    .io_write       (io_write),
    .io_read        (io_read),
    .io_offset      (io_offset),
    .wdata          (wdata),
    .ram_q          (ram_q),
    .video_q        (video_q),
    .io_rdata       (io_rdata)
  );

  // Single RAM, the state port wins while ss_active is high
  main_ram ram0 (
    .clk       (clk),
    .cpu_addr  (ram_addr),
    .cpu_data  (wdata),
    .cpu_wren  (ram_wren),
    .ss_active (ss_active),
    .ss_addr   (ss_addr),
    .ss_data   (ss_data),
    .ss_wren   (ss_wren),
    .q         (ram_q)
  );

  assign ss_q = ram_q;

  video_ram vram0 (
    .clk       (clk),
    .cpu_addr  (video_cpu_addr),
    .cpu_data  (wdata),
    .cpu_wren  (video_wren),
    .cpu_q     (video_q),
    .disp_addr (video_addr),
    .disp_q    (video_data)
  );

  io_regs io0 (
    .clk            (clk),
    .reset_n        (reset_n),
    .io_write       (io_write),
    .io_read        (io_read),
    .io_offset      (io_offset),
    .wdata          (wdata),
    .io_rdata       (io_rdata),
    .k0             (k0),
    .k1             (k1),
    .timer_value    (timer_value),
    .clock_factor   (clock_factor),
    .timer_reset    (timer_reset),
    .factor_clear   (factor_clear),
    .buzzer_enabled (buzzer_enabled),
    .buzzer_freq    (buzzer_freq),
    .lcd_all_off    (lcd_all_off),
    .lcd_all_on     (lcd_all_on),
    .irq            (irq)
  );

  clock_timer timer0 (
    .clk          (clk),
    .reset_n      (reset_n),
    .clk_en       (clk_en),
    .timer_reset  (timer_reset),
    .factor_clear (factor_clear),
    .timer_value  (timer_value),
    .clock_factor (clock_factor)
  );

  buzzer tone_gen (
    .clk            (clk),
    .reset_n        (reset_n),
    .clk_en         (clk_en),
    .buzzer_enabled (buzzer_enabled),
    .buzzer_freq    (buzzer_freq),
    .tone           (buzzer)
  );

endmodule

/* rtl/mcu_pkg.sv */
package mcu_pkg;

  // One data nibble on the CPU bus
  typedef logic [3:0] nibble_t;

  // Nibble address as seen by the CPU
  typedef logic [11:0] cpu_addr_t;

  // Main RAM word address, 640 words used
  typedef logic [9:0] ram_addr_t;

  // Video RAM word address, shared by both ports
  typedef logic [7:0] video_addr_t;

  // Register offset inside the I/O page
  typedef logic [7:0] io_offset_t;

endpackage

/* rtl/video_ram.sv */
`timescale 1ns/1ps
`include "mcu_defs.svh"

module video_ram import mcu_pkg::*; (
  input  logic        clk,
  input  video_addr_t cpu_addr,
  input  nibble_t     cpu_data,
  input  logic        cpu_wren,
  output nibble_t     cpu_q,
  input  video_addr_t disp_addr,
  output nibble_t     disp_q
);

  nibble_t     mem [0:`VIDEO_SIZE-1];

  video_addr_t disp_idx;

  // Out of range display reads fall back to word 0
  assign disp_idx = (disp_addr < `VIDEO_SIZE) ? disp_addr : '0;

  // CPU port, read and write
  always_ff @(posedge clk) begin
    if (cpu_wren) begin
      mem[cpu_addr] <= cpu_data;
    end
    cpu_q <= mem[cpu_addr];
  end

  // Display port is read only
  always_ff @(posedge clk) begin
    disp_q <= mem[disp_idx];
  end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then judge the run from its log
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f list.f --top-module tb_mcu_peripherals -o tb_sim > build.log 2>&1 \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { cat build.log; echo "Build or simulation exited with an error"; }
cat sim.log 2>/dev/null
grep -q "Test failures found" sim.log 2>/dev/null && exit 1
grep -q "All tests passed!" sim.log 2>/dev/null || exit 1
exit 0

/* test/tb_mcu_peripherals.sv */
`timescale 1ns/1ps
`include "mcu_defs.svh"

module tb_mcu_peripherals import mcu_pkg::*; ();

  localparam int CLK_HALF = 20;

  typedef struct packed {
    cpu_addr_t addr;
    nibble_t   data;
    logic      write;
    nibble_t   expected;
  } bus_step_t;

  logic        clk;
  logic        reset_n;
  logic        clk_en = 1'b0;
  cpu_addr_t   mem_addr;
  nibble_t     mem_write_data;
  logic        mem_write_en;
  logic        mem_read_en;
  nibble_t     mem_read_data;
  video_addr_t video_addr;
  nibble_t     video_data;
  nibble_t     k0;
  nibble_t     k1;
  logic        buzzer;
  logic        irq;
  logic        lcd_all_off;
  logic        lcd_all_on;
  logic        ss_active;
  logic        ss_wren;
  ram_addr_t   ss_addr;
  nibble_t     ss_data;
  nibble_t     ss_q;

  logic [1:0]  phase = 2'd0;
  int          ticks = 0;
  int          seed;
  bus_step_t   steps[$];

  mcu_peripherals dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_HALF) clk = ~clk;
  end

  // One clk_en tick every fourth cycle
  always @(negedge clk) begin
    phase  <= phase + 2'd1;
    clk_en <= (phase == 2'd2);
  end

  always @(posedge clk) begin
    if (clk_en) begin
      ticks <= ticks + 1;
    end
  end

  task automatic stop_run();
    $display("Test failures found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check(input string what, input int actual, input int expected);
    if (actual != expected) begin
      $display("Error at %0d ns: %s gave %0h, expected %0h", $time, what, actual, expected);
      stop_run();
    end
  endtask

  task automatic timed_out(input string what);
    $display("Timeout at %0d ns while waiting for %s", $time, what);
    stop_run();
  endtask

  // Returns on the falling edge right after a tick cycle
  task automatic wait_tick();
    int n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > 8) timed_out("a clk_en tick");
    end while (!clk_en);
  endtask

  task automatic skip_ticks(input int count);
    for (int i = 0; i < count; i++) begin
      wait_tick();
    end
  endtask

  // Bus held for the whole tick period, data sampled after the tick
  task automatic bus_access(input cpu_addr_t addr, input nibble_t data, input logic write,
                            output nibble_t rdata);
    wait_tick();
    mem_addr       = addr;
    mem_write_data = data;
    mem_write_en   = write;
    mem_read_en    = !write;
    wait_tick();
    rdata          = mem_read_data;
    mem_write_en   = 1'b0;
    mem_read_en    = 1'b0;
  endtask

  task automatic bus_write(input cpu_addr_t addr, input nibble_t data);
    nibble_t ignored;
    bus_access(addr, data, 1'b1, ignored);
  endtask

  task automatic bus_read(input cpu_addr_t addr, output nibble_t rdata);
    bus_access(addr, 4'h0, 1'b0, rdata);
  endtask

  function automatic cpu_addr_t io_addr(input io_offset_t offset);
    return {`IO_PAGE, offset};
  endfunction

  function automatic bus_step_t make_step(input cpu_addr_t addr, input nibble_t data,
                                          input logic write, input nibble_t expected);
    bus_step_t s;
    s.addr     = addr;
    s.data     = data;
    s.write    = write;
    s.expected = expected;
    return s;
  endfunction

  // Display port data shows up one cycle after the address
  task automatic check_display(input video_addr_t addr, input nibble_t expected);
    @(negedge clk);
    video_addr = addr;
    @(negedge clk);
    check($sformatf("display word %02h", addr), int'(video_data), int'(expected));
  endtask

  task automatic wait_irq(input logic level, input int limit);
    int n = 0;
    while (irq !== level) begin
      @(negedge clk);
      n++;
      if (n > limit) timed_out($sformatf("irq = %0b", level));
    end
  endtask

  task automatic wait_buzzer_toggle(input int limit, output int tick_at);
    logic start;
    int   n = 0;
    start = buzzer;
    while (buzzer === start) begin
      @(negedge clk);
      n++;
      if (n > limit) timed_out("a buzzer toggle");
    end
    tick_at = ticks;
  endtask

  // Timer steps once per TIMER_PRESCALE ticks
  function automatic logic [7:0] timer_after(input int elapsed);
    return 8'(elapsed / `TIMER_PRESCALE);
  endfunction

  task automatic build_table();
    nibble_t r0;
    nibble_t r1;
    nibble_t r2;
    r0 = 4'($random(seed));
    r1 = 4'($random(seed));
    r2 = 4'($random(seed));
    // Main RAM edges and unmapped space
    steps.push_back(make_step(12'h000, r0, 1'b1, 4'h0));
    steps.push_back(make_step(12'h13A, r1, 1'b1, 4'h0));
    steps.push_back(make_step(12'h27F, r2, 1'b1, 4'h0));
    steps.push_back(make_step(12'h000, 4'h0, 1'b0, r0));
    steps.push_back(make_step(12'h13A, 4'h0, 1'b0, r1));
    steps.push_back(make_step(12'h27F, 4'h0, 1'b0, r2));
    steps.push_back(make_step(12'h280, 4'h0, 1'b0, 4'h0));
    steps.push_back(make_step(12'hD00, 4'h0, 1'b0, 4'h0));
    // Both display segments
    steps.push_back(make_step(12'hE00, 4'h7, 1'b1, 4'h0));
    steps.push_back(make_step(12'hE05, 4'hA, 1'b1, 4'h0));
    steps.push_back(make_step(12'hE85, 4'h6, 1'b1, 4'h0));
    steps.push_back(make_step(12'hE05, 4'h0, 1'b0, 4'hA));
    steps.push_back(make_step(12'hE85, 4'h0, 1'b0, 4'h6));
    // I/O defaults, then register writes
    steps.push_back(make_step(12'hF54, 4'h0, 1'b0, 4'hF));
    steps.push_back(make_step(12'hF74, 4'h0, 1'b0, 4'hF));
    steps.push_back(make_step(12'hF41, 4'h0, 1'b0, 4'hF));
    steps.push_back(make_step(12'hF71, 4'h0, 1'b0, 4'h8));
    steps.push_back(make_step(12'hF10, 4'h0, 1'b0, 4'h0));
    steps.push_back(make_step(12'hF14, 4'h3, 1'b1, 4'h0));
    steps.push_back(make_step(12'hF15, 4'hC, 1'b1, 4'h0));
    steps.push_back(make_step(12'hF41, 4'h9, 1'b1, 4'h0));
    steps.push_back(make_step(12'hF14, 4'h0, 1'b0, 4'h3));
    steps.push_back(make_step(12'hF15, 4'h0, 1'b0, 4'hC));
    steps.push_back(make_step(12'hF41, 4'h0, 1'b0, 4'h9));
    steps.push_back(make_step(12'hF40, 4'h0, 1'b0, 4'h5));
    steps.push_back(make_step(12'hF42, 4'h0, 1'b0, 4'hA));
  endtask

  initial begin
    nibble_t    rdata;
    nibble_t    ss_value;
    nibble_t    freq_value;
    logic [7:0] expected_timer;
    int         t_reset;
    int         t_first;
    int         t_second;
    int         half;

    seed           = 32'h3dc4;
    reset_n        = 1'b0;
    mem_addr       = '0;
    mem_write_data = '0;
    mem_write_en   = 1'b0;
    mem_read_en    = 1'b0;
    video_addr     = '0;
    k0             = 4'h5;
    k1             = 4'hA;
    ss_active      = 1'b0;
    ss_wren        = 1'b0;
    ss_addr        = '0;
    ss_data        = '0;
    repeat (4) @(negedge clk);
    reset_n = 1'b1;

    check("mem_read_data after reset", int'(mem_read_data), 0);
    check("irq after reset", int'(irq), 0);
    check("lcd_all_off after reset", int'(lcd_all_off), 1);

    build_table();
    foreach (steps[i]) begin
      if (steps[i].write) begin
        bus_write(steps[i].addr, steps[i].data);
      end else begin
        bus_read(steps[i].addr, rdata);
        check($sformatf("read of %03h", steps[i].addr), int'(rdata),
              int'(steps[i].expected));
      end
    end

    // Upper segment lands 0x50 words in, out of range reads word 0
    check_display(8'h05, 4'hA);
    check_display(8'h55, 4'h6);
    check_display(8'hB0, 4'h7);

    bus_write(io_addr(`IO_LCD_CTRL), 4'h4);
    check("lcd_all_on", int'(lcd_all_on), 1);
    check("lcd_all_off", int'(lcd_all_off), 0);

    // Count ticks from the timer reset
    bus_write(io_addr(`IO_TIMER_RESET), 4'h2);
    t_reset = ticks;
    skip_ticks(70);
    bus_read(io_addr(`IO_TIMER_LO), rdata);
    expected_timer = timer_after(ticks - t_reset - 1);
    check("timer low nibble", int'(rdata), int'(expected_timer[3:0]));
    bus_read(io_addr(`IO_TIMER_HI), rdata);
    expected_timer = timer_after(ticks - t_reset - 1);
    check("timer high nibble", int'(rdata), int'(expected_timer[7:4]));

    // Fresh timer and cleared factor, then wait for the 32 Hz flag
    bus_write(io_addr(`IO_TIMER_RESET), 4'h2);
    bus_read(io_addr(`IO_CLOCK_FACTOR), rdata);
    bus_write(io_addr(`IO_CLOCK_MASK), 4'h1);
    check("irq before first timer flag", int'(irq), 0);
    wait_irq(1'b1, 200);
    bus_read(io_addr(`IO_CLOCK_FACTOR), rdata);
    check("clock factor nonzero", int'(rdata != 4'h0), 1);
    wait_irq(1'b0, 8);

    // Random word that differs from the one the CPU left at 0x13A
    ss_value = steps[1].data ^ (4'($random(seed)) | 4'h1);
    @(negedge clk);
    ss_active = 1'b1;
    ss_addr   = 10'h13A;
    ss_data   = ss_value;
    ss_wren   = 1'b1;
    @(negedge clk);
    ss_wren = 1'b0;
    @(negedge clk);
    check("ss_q after state write", int'(ss_q), int'(ss_value));
    bus_write(12'h13A, ~ss_value);
    @(negedge clk);
    check("ss_q after CPU write", int'(ss_q), int'(ss_value));
    ss_active = 1'b0;
    bus_read(12'h13A, rdata);
    check("CPU read of state data", int'(rdata), int'(ss_value));

    // Default control keeps the tone off
    for (int i = 0; i < 64; i++) begin
      @(negedge clk);
      check("buzzer while disabled", int'(buzzer), 0);
    end
    freq_value = 4'h5;
    bus_write(io_addr(`IO_BUZZ_FREQ), freq_value);
    bus_read(io_addr(`IO_BUZZ_FREQ), rdata);
    check("buzzer frequency", int'(rdata), int'(freq_value));
    // Two ticks plus the low three frequency bits
    half = 2 + int'(freq_value[2:0]);
    bus_write(io_addr(`IO_BUZZ_CTRL), 4'h0);
    wait_buzzer_toggle(200, t_first);
    wait_buzzer_toggle(200, t_second);
    check("buzzer half-period in ticks", t_second - t_first, half);
    wait_buzzer_toggle(200, t_first);
    check("buzzer half-period in ticks", t_first - t_second, half);

    $display("All tests passed!");
    $finish;
  end

endmodule
